/* compile.f */
logic/mem_bus_pkg.sv
logic/mem_req_pkg.sv
logic/mem_arbiter.sv
logic/req_fifo.sv
logic/line_sequencer.sv
logic/main_mem_ctrl.sv
tb/iomem_model.sv
tb/main_mem_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module main_mem_ctrl_tb

./obj_dir/Vmain_mem_ctrl_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
grep -q "All tests passed!" sim.log
echo "Simulation PASSED"

/* tb/main_mem_ctrl_tb.sv */
`default_nettype none

module main_mem_ctrl_tb;

    import mem_bus_pkg::*;
    import mem_req_pkg::*;

    localparam int NUM_TESTS     = 8;
    localparam int WATCHDOG_TIME = NUM_TESTS * BEATS_PER_LINE * 64 * 8;

    localparam logic [LINE_W-1:0] LINE_A = 128'hDEAD_0003_BEEF_0002_CAFE_0001_F00D_0000;
    localparam logic [LINE_W-1:0] LINE_B = 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210;

    typedef logic [LINE_W-1:0] val_t;

    typedef struct packed {
        logic              fetch;
        logic              data;
        logic              write;
        logic [ADDR_W-1:0] fetch_addr;
        logic [ADDR_W-1:0] data_addr;
        logic [LINE_W-1:0] wline;
        logic [LINE_W-1:0] exp_fetch_line;
        logic [LINE_W-1:0] exp_data_line;
    } entry_t;

    logic              clk_i;
    logic              arst_n_i;
    logic              fetch_req_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic              data_req_i;
    logic [ADDR_W-1:0] data_addr_i;
    logic              data_write_i;
    logic [LINE_W-1:0] data_wline_i;
    logic              iomem_ready;
    logic [WORD_W-1:0] iomem_rdata;
    logic              fetch_done_o;
    logic              data_done_o;
    logic [LINE_W-1:0] rline_o;
    logic              mem_idle_o;
    logic              iomem_valid_o;
    logic [ADDR_W-1:0] iomem_addr_o;
    logic [WORD_W-1:0] iomem_wdata_o;
    logic [STRB_W-1:0] iomem_wstrb_o;

    entry_t            tests [NUM_TESTS];
    int                fetch_dones = 0;
    int                data_dones = 0;
    int                data_at_fetch = 0;
    logic [LINE_W-1:0] fetch_line_got;
    logic [LINE_W-1:0] data_line_got;
    logic              last_valid = 1'b0;
    logic              last_ready = 1'b0;
    logic [ADDR_W-1:0] last_addr;
    logic [WORD_W-1:0] last_wdata;

    main_mem_ctrl dut0 (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_write_i  (data_write_i),
        .data_wline_i  (data_wline_i),
        .iomem_ready_i (iomem_ready),
        .iomem_rdata_i (iomem_rdata),
        .fetch_done_o  (fetch_done_o),
        .data_done_o   (data_done_o),
        .rline_o       (rline_o),
        .mem_idle_o    (mem_idle_o),
        .iomem_valid_o (iomem_valid_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_wdata_o (iomem_wdata_o),
        .iomem_wstrb_o (iomem_wstrb_o)
    );

    iomem_model model0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (iomem_valid_o),
        .addr_i   (iomem_addr_o),
        .wdata_i  (iomem_wdata_o),
        .wstrb_i  (iomem_wstrb_o),
        .ready_o  (iomem_ready),
        .rdata_o  (iomem_rdata)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all requests completed");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input val_t got, input val_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Line as the bus memory holds it after reset, word k at addr + 4k
    function automatic logic [LINE_W-1:0] reset_image_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            line[WORD_W*k +: WORD_W] = (addr + ADDR_W'(4 * k)) ^ 32'h5A5A_0000;
        end
        return line;
    endfunction

    function automatic entry_t make_entry(input logic fetch, input logic data, input logic write,
                                          input logic [ADDR_W-1:0] fetch_addr,
                                          input logic [ADDR_W-1:0] data_addr,
                                          input logic [LINE_W-1:0] wline,
                                          input logic [LINE_W-1:0] exp_fetch_line,
                                          input logic [LINE_W-1:0] exp_data_line);
        return '{fetch, data, write, fetch_addr, data_addr, wline, exp_fetch_line,
                 exp_data_line};
    endfunction

    // Done pulses, read lines and stalled beats seen between clock edges
    always @(negedge clk_i) begin
        if (fetch_done_o) begin
            fetch_line_got = rline_o;
            data_at_fetch  = data_dones;
            fetch_dones    = fetch_dones + 1;
        end
        if (data_done_o) begin
            data_line_got = rline_o;
            data_dones    = data_dones + 1;
        end
        if (arst_n_i && last_valid && !last_ready) begin
            check_value("iomem_valid_o", val_t'(iomem_valid_o), val_t'(1'b1));
            check_value("iomem_addr_o", val_t'(iomem_addr_o), val_t'(last_addr));
            check_value("iomem_wdata_o", val_t'(iomem_wdata_o), val_t'(last_wdata));
        end
        last_valid = iomem_valid_o;
        last_ready = iomem_ready;
        last_addr  = iomem_addr_o;
        last_wdata = iomem_wdata_o;
    end

    // Data request goes to the bus first when both are present
    task automatic check_beats(input entry_t e, input int start);
        req_src_e          order [2];
        int                num_req;
        int                idx;
        logic [ADDR_W-1:0] base;
        logic              wr;
        num_req = 0;
        if (e.data) begin
            order[num_req] = SRC_DATA;
            num_req++;
        end
        if (e.fetch) begin
            order[num_req] = SRC_FETCH;
            num_req++;
        end
        check_value("beat count", val_t'(model0.beat_count - start),
                    val_t'(num_req * BEATS_PER_LINE));
        for (int r = 0; r < num_req; r++) begin
            base = (order[r] == SRC_DATA) ? e.data_addr : e.fetch_addr;
            // 16 byte line, low address bits dropped
            base = base & ~32'h0000_000F;
            wr   = (order[r] == SRC_DATA) && e.write;
            for (int k = 0; k < BEATS_PER_LINE; k++) begin
                idx = start + r * BEATS_PER_LINE + k;
                check_value("iomem_addr_o", val_t'(model0.log_addr[idx]),
                            val_t'(base + ADDR_W'(4 * k)));
                check_value("iomem_wstrb_o", val_t'(model0.log_strb[idx]),
                            val_t'(wr ? 4'hF : 4'h0));
                if (wr) begin
                    check_value("iomem_wdata_o", val_t'(model0.log_wdata[idx]),
                                val_t'(e.wline[WORD_W*k +: WORD_W]));
                end
            end
        end
    endtask

    task automatic apply_entry(input int n);
        entry_t e;
        int     beat_start;
        int     f_start;
        int     d_start;
        int     exp_f;
        int     exp_d;
        e          = tests[n];
        exp_f      = int'(e.fetch);
        exp_d      = int'(e.data);
        check_value("mem_idle_o", val_t'(mem_idle_o), val_t'(1'b1));
        check_value("iomem_valid_o", val_t'(iomem_valid_o), val_t'(1'b0));
        beat_start = model0.beat_count;
        f_start    = fetch_dones;
        d_start    = data_dones;
        @(posedge clk_i);
        fetch_req_i  <= e.fetch;
        fetch_addr_i <= e.fetch_addr;
        data_req_i   <= e.data;
        data_addr_i  <= e.data_addr;
        data_write_i <= e.write;
        data_wline_i <= e.wline;
        @(posedge clk_i);
        fetch_req_i <= 1'b0;
        data_req_i  <= 1'b0;
        @(negedge clk_i);
        check_value("mem_idle_o", val_t'(mem_idle_o), val_t'(1'b0));
        @(posedge clk_i);
        // Busy until the last done pulse of this entry has been seen
        while ((fetch_dones - f_start) < exp_f || (data_dones - d_start) < exp_d) begin
            @(negedge clk_i);
            check_value("mem_idle_o", val_t'(mem_idle_o), val_t'(1'b0));
            @(posedge clk_i);
        end
        @(negedge clk_i);
        check_value("mem_idle_o", val_t'(mem_idle_o), val_t'(1'b1));
        check_value("iomem_valid_o", val_t'(iomem_valid_o), val_t'(1'b0));
        check_value("fetch_done_o count", val_t'(fetch_dones - f_start), val_t'(exp_f));
        check_value("data_done_o count", val_t'(data_dones - d_start), val_t'(exp_d));
        if (e.fetch) begin
            check_value("rline_o", fetch_line_got, e.exp_fetch_line);
        end
        if (e.data && !e.write) begin
            check_value("rline_o", data_line_got, e.exp_data_line);
        end
        if (e.fetch && e.data) begin
            check_value("data_done_o order", val_t'(data_at_fetch - d_start), val_t'(1));
        end
        check_beats(e, beat_start);
    endtask

    initial begin
        tests[0] = make_entry(1'b1, 1'b0, 1'b0, 32'h100, 32'h0, '0,
                              reset_image_line(32'h100), '0);
        tests[1] = make_entry(1'b0, 1'b1, 1'b1, 32'h0, 32'h200, LINE_A, '0, '0);
        tests[2] = make_entry(1'b0, 1'b1, 1'b0, 32'h0, 32'h200, '0, '0, LINE_A);
        tests[3] = make_entry(1'b1, 1'b1, 1'b0, 32'h040, 32'h080, '0,
                              reset_image_line(32'h040), reset_image_line(32'h080));
        tests[4] = make_entry(1'b1, 1'b0, 1'b0, 32'h30C, 32'h0, '0,
                              reset_image_line(32'h300), '0);
        tests[5] = make_entry(1'b0, 1'b1, 1'b1, 32'h0, 32'h3A7, LINE_B, '0, '0);
        tests[6] = make_entry(1'b1, 1'b1, 1'b0, 32'h0F4, 32'h3A9, '0,
                              reset_image_line(32'h0F0), LINE_B);
        // Fetch sees the line written by entry 1
        tests[7] = make_entry(1'b1, 1'b1, 1'b1, 32'h20C, 32'h080, LINE_B, LINE_A, '0);

        arst_n_i     = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_write_i = 1'b0;
        data_wline_i = '0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("fetch_done_o", val_t'(fetch_done_o), val_t'(1'b0));
        check_value("data_done_o", val_t'(data_done_o), val_t'(1'b0));
        for (int n = 0; n < NUM_TESTS; n++) begin
            apply_entry(n);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/iomem_model.sv */
`default_nettype none

module iomem_model (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           valid_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] addr_i,
    input  logic [mem_bus_pkg::WORD_W-1:0] wdata_i,
    input  logic [mem_bus_pkg::STRB_W-1:0] wstrb_i,
    output logic                           ready_o,
    output logic [mem_bus_pkg::WORD_W-1:0] rdata_o
);

    import mem_bus_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int LOG_DEPTH = 128;

    logic [WORD_W-1:0] mem       [MEM_WORDS];
    logic [ADDR_W-1:0] log_addr  [LOG_DEPTH];
    logic [STRB_W-1:0] log_strb  [LOG_DEPTH];
    logic [WORD_W-1:0] log_wdata [LOG_DEPTH];
    int                beat_count = 0;
    integer            seed = 32'h4e45;
    integer            draw;
    logic [7:0]        word_idx;

    // 256 words cover byte addresses 0x000 to 0x3FF
    assign word_idx = addr_i[9:2];
    assign rdata_o  = mem[word_idx];

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_o    <= 1'b0;
            beat_count <= 0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= WORD_W'(i * 4) ^ 32'h5A5A_0000;
            end
        end else begin
            // Fresh stall decision every cycle
            draw = $random(seed);
            ready_o <= draw[0];
            if (valid_i && ready_o) begin
                if (beat_count < LOG_DEPTH) begin
                    log_addr[beat_count]  <= addr_i;
                    log_strb[beat_count]  <= wstrb_i;
                    log_wdata[beat_count] <= wdata_i;
                end
                beat_count <= beat_count + 1;
                for (int b = 0; b < STRB_W; b++) begin
                    if (wstrb_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/main_mem_ctrl.sv */
`default_nettype none

module main_mem_ctrl (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           fetch_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                           data_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] data_addr_i,
    input  logic                           data_write_i,
    input  logic [mem_bus_pkg::LINE_W-1:0] data_wline_i,
    input  logic                           iomem_ready_i,
    input  logic [mem_bus_pkg::WORD_W-1:0] iomem_rdata_i,
    output logic                           fetch_done_o,
    output logic                           data_done_o,
    output logic [mem_bus_pkg::LINE_W-1:0] rline_o,
    output logic                           mem_idle_o,
    output logic                           iomem_valid_o,
    output logic [mem_bus_pkg::ADDR_W-1:0] iomem_addr_o,
    output logic [mem_bus_pkg::WORD_W-1:0] iomem_wdata_o,
    output logic [mem_bus_pkg::STRB_W-1:0] iomem_wstrb_o
);

    import mem_bus_pkg::*;
    import mem_req_pkg::*;

    // Arbiter to queue
    logic              push;
    req_src_e          push_src;
    req_op_e           push_op;
    logic [ADDR_W-1:0] push_addr;
    logic [LINE_W-1:0] push_wline;
    logic              credit_ret;

    // Queue to sequencer
    logic              pop;
    logic              head_valid;
    req_src_e          head_src;
    req_op_e           head_op;
    logic [ADDR_W-1:0] head_addr;
    logic [LINE_W-1:0] head_wline;

    logic arb_idle;
    logic fifo_empty;
    logic seq_idle;

    mem_arbiter arb0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_write_i (data_write_i),
        .data_wline_i (data_wline_i),
        .credit_ret_i (credit_ret),
        .push_o       (push),
        .push_src_o   (push_src),
        .push_op_o    (push_op),
        .push_addr_o  (push_addr),
        .push_wline_o (push_wline),
        .arb_idle_o   (arb_idle)
    );

    req_fifo fifo0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (push),
        .push_src_i   (push_src),
        .push_op_i    (push_op),
        .push_addr_i  (push_addr),
        .push_wline_i (push_wline),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_src_o   (head_src),
        .head_op_o    (head_op),
        .head_addr_o  (head_addr),
        .head_wline_o (head_wline),
        .credit_ret_o (credit_ret),
        .fifo_empty_o (fifo_empty)
    );

    line_sequencer seq0 (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .head_valid_i  (head_valid),
        .head_src_i    (head_src),
        .head_op_i     (head_op),
        .head_addr_i   (head_addr),
        .head_wline_i  (head_wline),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i),
        .pop_o         (pop),
        .iomem_valid_o (iomem_valid_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_wdata_o (iomem_wdata_o),
        .iomem_wstrb_o (iomem_wstrb_o),
        .fetch_done_o  (fetch_done_o),
        .data_done_o   (data_done_o),
        .rline_o       (rline_o),
        .seq_idle_o    (seq_idle)
    );

    // Idle only with nothing pending, queued or on the bus
    assign mem_idle_o = arb_idle && fifo_empty && seq_idle;

endmodule

`default_nettype wire

/* logic/line_sequencer.sv */
`default_nettype none

module line_sequencer (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           head_valid_i,
    input  mem_req_pkg::req_src_e          head_src_i,
    input  mem_req_pkg::req_op_e           head_op_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] head_addr_i,
    input  logic [mem_bus_pkg::LINE_W-1:0] head_wline_i,
    input  logic                           iomem_ready_i,
    input  logic [mem_bus_pkg::WORD_W-1:0] iomem_rdata_i,
    output logic                           pop_o,
    output logic                           iomem_valid_o,
    output logic [mem_bus_pkg::ADDR_W-1:0] iomem_addr_o,
    output logic [mem_bus_pkg::WORD_W-1:0] iomem_wdata_o,
    output logic [mem_bus_pkg::STRB_W-1:0] iomem_wstrb_o,
    output logic                           fetch_done_o,
    output logic                           data_done_o,
    output logic [mem_bus_pkg::LINE_W-1:0] rline_o,
    output logic                           seq_idle_o
);

    import mem_bus_pkg::*;
    import mem_req_pkg::*;

    seq_state_e            state_q;
    logic [BEAT_IDX_W-1:0] beat_q;
    req_src_e              src_q;
    req_op_e               op_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [LINE_W-1:0]     line_q;
    logic                  beat_done;
    logic                  last_beat;
    logic                  is_write;

    assign pop_o     = (state_q == SEQ_IDLE) && head_valid_i;
    assign beat_done = (state_q == SEQ_BEAT) && iomem_ready_i;
    assign last_beat = beat_q == BEAT_IDX_W'(BEATS_PER_LINE - 1);
    assign is_write  = op_q == OP_WRITE_LINE;

    // Beat address is line base plus word index
    assign iomem_valid_o = state_q == SEQ_BEAT;
    assign iomem_addr_o  = {addr_q[ADDR_W-1:LINE_OFFSET_W], beat_q, 2'b00};
    // Current word always sits in the low bits of the line register
    assign iomem_wdata_o = line_q[WORD_W-1:0];
    assign iomem_wstrb_o = (iomem_valid_o && is_write) ? {STRB_W{1'b1}} : {STRB_W{1'b0}};

    // Done goes to whichever stage owns the request
    assign fetch_done_o = (state_q == SEQ_DONE) && (src_q == SRC_FETCH);
    assign data_done_o  = (state_q == SEQ_DONE) && (src_q == SRC_DATA);
    assign rline_o      = line_q;
    assign seq_idle_o   = state_q == SEQ_IDLE;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= SEQ_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (head_valid_i) begin
                        state_q <= SEQ_BEAT;
                        beat_q  <= '0;
                    end
                end
                SEQ_BEAT: begin
                    // Hold everything until the bus takes the beat
                    if (iomem_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= SEQ_DONE;
                        end
                    end
                end
                SEQ_DONE: begin
                    state_q <= SEQ_IDLE;
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Line register doubles as write shifter and read assembler
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            src_q  <= head_src_i;
            op_q   <= head_op_i;
            addr_q <= head_addr_i;
            line_q <= head_wline_i;
        end else if (beat_done) begin
            if (is_write) begin
                // rotate, so the full line is back in place after four beats
                line_q <= {line_q[WORD_W-1:0], line_q[LINE_W-1:WORD_W]};
            end else begin
                line_q <= {iomem_rdata_i, line_q[LINE_W-1:WORD_W]};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/req_fifo.sv */
`default_nettype none

module req_fifo (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           push_i,
    input  mem_req_pkg::req_src_e          push_src_i,
    input  mem_req_pkg::req_op_e           push_op_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] push_addr_i,
    input  logic [mem_bus_pkg::LINE_W-1:0] push_wline_i,
    input  logic                           pop_i,
    output logic                           head_valid_o,
    output mem_req_pkg::req_src_e          head_src_o,
    output mem_req_pkg::req_op_e           head_op_o,
    output logic [mem_bus_pkg::ADDR_W-1:0] head_addr_o,
    output logic [mem_bus_pkg::LINE_W-1:0] head_wline_o,
    output logic                           credit_ret_o,
    output logic                           fifo_empty_o
);

    import mem_bus_pkg::*;
    import mem_req_pkg::*;

    typedef logic [$clog2(REQ_DEPTH)-1:0] ptr_t;

    ptr_t                wr_ptr_q;
    ptr_t                rd_ptr_q;
    logic [CREDIT_W-1:0] count_q;
    logic                pop_ok;

    req_src_e          src_mem   [REQ_DEPTH];
    req_op_e           op_mem    [REQ_DEPTH];
    logic [ADDR_W-1:0] addr_mem  [REQ_DEPTH];
    logic [LINE_W-1:0] wline_mem [REQ_DEPTH];

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid_o = count_q != '0;
    assign fifo_empty_o = count_q == '0;
    assign pop_ok       = pop_i && head_valid_o;
    // Freed slot goes straight back to the arbiter
    assign credit_ret_o = pop_ok;

    assign head_src_o   = src_mem[rd_ptr_q];
    assign head_op_o    = op_mem[rd_ptr_q];
    assign head_addr_o  = addr_mem[rd_ptr_q];
    assign head_wline_o = wline_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            src_mem[wr_ptr_q]   <= push_src_i;
            op_mem[wr_ptr_q]    <= push_op_i;
            addr_mem[wr_ptr_q]  <= push_addr_i;
            wline_mem[wr_ptr_q] <= push_wline_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           fetch_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                           data_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] data_addr_i,
    input  logic                           data_write_i,
    input  logic [mem_bus_pkg::LINE_W-1:0] data_wline_i,
    input  logic                           credit_ret_i,
    output logic                           push_o,
    output mem_req_pkg::req_src_e          push_src_o,
    output mem_req_pkg::req_op_e           push_op_o,
    output logic [mem_bus_pkg::ADDR_W-1:0] push_addr_o,
    output logic [mem_bus_pkg::LINE_W-1:0] push_wline_o,
    output logic                           arb_idle_o
);

    import mem_bus_pkg::*;
    import mem_req_pkg::*;

    logic                fetch_pend_q;
    logic [ADDR_W-1:0]   fetch_addr_q;
    logic                data_pend_q;
    logic [ADDR_W-1:0]   data_addr_q;
    req_op_e             data_op_q;
    logic [LINE_W-1:0]   data_wline_q;
    logic [CREDIT_W-1:0] credits_q;
    logic                push_data;
    logic                push_fetch;

    function automatic logic [ADDR_W-1:0] line_align(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
    endfunction

    // Data slot has priority, fetch goes only when data slot is empty
    assign push_o     = (data_pend_q || fetch_pend_q) && (credits_q != '0);
    assign push_data  = push_o && data_pend_q;
    assign push_fetch = push_o && !data_pend_q;

    assign push_src_o   = data_pend_q ? SRC_DATA : SRC_FETCH;
    assign push_op_o    = data_pend_q ? data_op_q : OP_READ_LINE;
    assign push_addr_o  = data_pend_q ? data_addr_q : fetch_addr_q;
    assign push_wline_o = data_wline_q;
    assign arb_idle_o   = !data_pend_q && !fetch_pend_q;

    // Pending flags, one slot per stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_pend_q <= 1'b0;
            data_pend_q  <= 1'b0;
        end else begin
            if (fetch_req_i) begin
                fetch_pend_q <= 1'b1;
            end else if (push_fetch) begin
                fetch_pend_q <= 1'b0;
            end
            if (data_req_i) begin
                data_pend_q <= 1'b1;
            end else if (push_data) begin
                data_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            fetch_addr_q <= line_align(fetch_addr_i);
        end
        if (data_req_i) begin
            data_addr_q  <= line_align(data_addr_i);
            data_op_q    <= data_write_i ? OP_WRITE_LINE : OP_READ_LINE;
            data_wline_q <= data_wline_i;
        end
    end

    // One credit per queue entry, returned on pop
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits_q <= CREDIT_W'(REQ_DEPTH);
        end else begin
            case ({push_o, credit_ret_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/mem_req_pkg.sv */
`default_nettype none

package mem_req_pkg;

    // Stage that issued the request
    typedef enum logic [0:0] {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } req_src_e;

    // Line operation
    typedef enum logic [0:0] {
        OP_READ_LINE  = 1'b0,
        OP_WRITE_LINE = 1'b1
    } req_op_e;

    // Line sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_BEAT = 2'd1,
        SEQ_DONE = 2'd2
    } seq_state_e;

    // Request queue depth, also the number of arbiter credits
    localparam int REQ_DEPTH = 2;
    localparam int CREDIT_W  = $clog2(REQ_DEPTH + 1);

endpackage

`default_nettype wire

/* logic/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Byte addressed iomem bus, one word per beat
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    // Cache line as seen by fetch and data stages
    localparam int LINE_W = 128;

    // Words moved per line transfer
    localparam int BEATS_PER_LINE = LINE_W / WORD_W;
    localparam int BEAT_IDX_W     = $clog2(BEATS_PER_LINE);

    // Line addresses keep these low bits at zero
    localparam int LINE_OFFSET_W = $clog2(LINE_W / 8);

endpackage

`default_nettype wire
